// File: src/aud_mix.sv
// One audio channel: deglitch, extension, stereo cross-mix,
// attenuation and saturating clamp, 8 cycles input to output
`timescale 1ns/1ps
`include "hal_cfg.svh"

module aud_mix
	import hal_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic [`HAL_AUD_W-1:0] i_sample,
	input  logic                  i_is_signed,
	input  logic [1:0]            i_mix,
	input  logic [4:0]            i_att,
	input  logic [`HAL_AUD_W-1:0] i_pre,
	output logic [`HAL_AUD_W-1:0] o_pre,
	output logic [`HAL_AUD_W-1:0] o_audio
);

	localparam int W = `HAL_AUD_W;

	logic [W-1:0] d1;
	logic [W-1:0] d2;
	logic [W-1:0] ca;
	aud_ext_t     ext_q;
	aud_ext_t     mix_q;
	aud_ext_t     att_q;
	logic [W-1:0] clip_q;

	////////////////////////////////////////
	// Deglitch
	////////////////////////////////////////

	// Core may change the sample across bits, take it once it holds
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_sample;
			d2 <= d1;
			if (d1 == d2)
				ca <= d2;
		end
	end

	////////////////////////////////////////
	// Arithmetic pipeline
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			ext_q   <= '0;
			mix_q   <= '0;
			att_q   <= '0;
			clip_q  <= '0;
			o_audio <= '0;
		end else begin
			// Unsigned samples are halved to fit the signed range
			ext_q <= i_is_signed ? {ca[W-1], ca} : {2'b00, ca[W-1:1]};

			// Partner's pre-mix is already at half scale
			case (i_mix)
				2'd0: mix_q <= ext_q;
				2'd1: mix_q <= ext_q - {{3{ext_q[W]}}, ext_q[W:3]}
				             + {{3{i_pre[W-1]}}, i_pre[W-1:2]};
				2'd2: mix_q <= ext_q - {{2{ext_q[W]}}, ext_q[W:2]}
				             + {{2{i_pre[W-1]}}, i_pre[W-1:1]};
				default: mix_q <= {ext_q[W], ext_q[W:1]} + {i_pre[W-1], i_pre};
			endcase

			if (i_att[4])
				att_q <= '0;
			else
				att_q <= mix_q >>> i_att[3:0];

			// Saturate on guard bit overflow
			if (att_q[W] ^ att_q[W-1])
				clip_q <= {att_q[W], {(W-1){~att_q[W]}}};
			else
				clip_q <= att_q[W-1:0];

			o_audio <= clip_q;
		end
	end

	assign o_pre = ext_q[W:1];

endmodule

// File: src/cmd_decoder.sv
// Command decoder: first strobe of a transfer takes the command byte,
// later strobes write config flags, LED override or volume attenuation
`timescale 1ns/1ps
`include "hal_cfg.svh"

module cmd_decoder
	import hal_pkg::*;
(
	input  logic       clk_sys,
	input  logic       resetd,
	input  host_cmd_t  i_cmd,
	input  logic       i_strobe,
	output cfg_flags_t o_cfg,
	output led_ovr_t   o_led_ovr,
	output logic [4:0] o_vol_att
);

	cmd_data_u  din;
	logic       has_cmd;
	logic [7:0] cmd;

	assign din = i_cmd.io_din;

	////////////////////////////////////////
	// Command sequencer
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= '0;
			o_cfg     <= '0;
			o_led_ovr <= '0;
			o_vol_att <= '0;
		end else if (!i_cmd.io_uio) begin
			// Channel closed, next strobe starts a new command
			has_cmd <= 1'b0;
		end else if (i_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_cmd.io_din[7:0];
			end else begin
				// Same word seen as flags or as LED pair
				case (cmd)
					`HAL_CMD_CFG: o_cfg     <= din.cfg;
					`HAL_CMD_LED: o_led_ovr <= din.led;
					`HAL_CMD_VOL: o_vol_att <= i_cmd.io_din[4:0];
					default: begin
						// Unknown command, data dropped
					end
				endcase
			end
		end
	end

endmodule

// File: src/hal_cfg.svh
// Widths, host command codes and identity constants
// for the housekeeping logic

`ifndef HAL_CFG_SVH
`define HAL_CFG_SVH

// Bus and datapath widths
`define HAL_GP_W        32
`define HAL_IO_W        16
`define HAL_AUD_W       16
`define HAL_SYNC_CNT_W  16

// Host command codes
`define HAL_CMD_CFG     8'h01
`define HAL_CMD_LED     8'h25
`define HAL_CMD_VOL     8'h26

// Host refuses to talk to a core with another signature
`define HAL_CORE_MAGIC  {24'h5CA623, 8'hA4}
`define HAL_IO_VER      2'd1

`endif

// File: src/hal_pkg.sv
// Shared types: host word, command data views,
// core audio and LED requests, datapath words
`include "hal_cfg.svh"

package hal_pkg;

	// Host general-purpose word, bit 31 first
	typedef struct packed {
		logic [1:0]           reset_req;
		logic [8:0]           rsvd_hi;
		logic                 io_uio;
		logic [1:0]           rsvd_mid;
		logic                 io_clk;
		logic                 rsvd_lo;
		logic [`HAL_IO_W-1:0] io_din;
	} host_cmd_t;

	typedef struct packed {
		logic [6:0] rsvd_hi;
		logic       hdmi_limited;
		logic       dvi_mode;
		logic       audio_96k;
		logic       ypbpr_en;
		logic       rsvd_4;
		logic       csync;
		logic       vga_scaler;
		logic [1:0] rsvd_lo;
	} cfg_flags_t;

	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_ovr_t;

	// One data word, read per command
	typedef union packed {
		cfg_flags_t cfg;
		led_ovr_t   led;
	} cmd_data_u;

	typedef struct packed {
		logic [`HAL_AUD_W-1:0] left;
		logic [`HAL_AUD_W-1:0] right;
		logic                  is_signed;
		logic [1:0]            mix;
	} core_audio_t;

	typedef struct packed {
		logic [1:0] power;
		logic [1:0] disk;
		logic       user;
	} led_req_t;

	// Sample with one guard bit
	typedef logic signed [`HAL_AUD_W:0] aud_ext_t;
	typedef logic [`HAL_SYNC_CNT_W-1:0] sync_cnt_t;

endpackage

// File: src/hps_io_port.sv
// Host port: two-stage synchroniser of the host word,
// io_clk strobe and acknowledge, identity and status word
`timescale 1ns/1ps
`include "hal_cfg.svh"

module hps_io_port
	import hal_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  host_cmd_t            i_gp_out,
	output host_cmd_t            o_cmd,
	output logic                 o_strobe,
	output logic [`HAL_GP_W-1:0] o_gp_in
);

	host_cmd_t            gp_meta;
	logic                 clk_prev;
	logic                 ack;
	logic [`HAL_GP_W-1:0] status_word;

	// Host word is asynchronous to clk_sys
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			gp_meta <= '0;
			o_cmd   <= '0;
		end else begin
			gp_meta <= i_gp_out;
			o_cmd   <= gp_meta;
		end
	end

	// One strobe per rising io_clk, ack one cycle behind it
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_prev <= 1'b0;
			o_strobe <= 1'b0;
			ack      <= 1'b0;
		end else begin
			clk_prev <= o_cmd.io_clk;
			o_strobe <= o_cmd.io_clk & ~clk_prev;
			ack      <= clk_prev;
		end
	end

	assign status_word = {1'b0, 12'd0, ack, `HAL_IO_VER, 16'd0};

	// Bit 31 reads high on the host side until the core is up,
	// so the magic word must answer without any clock
	assign o_gp_in = i_gp_out.reset_req[1] ? status_word : `HAL_CORE_MAGIC;

endmodule

// File: src/sync_fix.sv
// Sync polarity fix: measures high and low widths of a sync
// signal and inverts it when the pulse is active low
`timescale 1ns/1ps
`include "hal_cfg.svh"

module sync_fix
	import hal_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic      s1;
	logic      s2;
	sync_cnt_t cnt;
	sync_cnt_t hi_width;
	sync_cnt_t lo_width;
	logic      pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			hi_width <= '0;
			lo_width <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rising edge closes a low phase
			if (s1 & ~s2)
				lo_width <= cnt;
			if (~s1 & s2)
				hi_width <= cnt;
			// Saturate on a stuck input
			if (s1 != s2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + sync_cnt_t'(1);
			pol <= hi_width > lo_width;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

// File: src/sys_hal_top.sv
// Housekeeping top: host port, command decoder, stereo mixer,
// sync polarity fix and mainboard LED merge
`timescale 1ns/1ps
`include "hal_cfg.svh"

module sys_hal_top
	import hal_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  host_cmd_t             i_gp_out,
	output logic [`HAL_GP_W-1:0]  o_gp_in,
	input  core_audio_t           i_core_audio,
	output logic [`HAL_AUD_W-1:0] o_audio_l,
	output logic [`HAL_AUD_W-1:0] o_audio_r,
	input  logic                  i_hs_raw,
	input  logic                  i_vs_raw,
	output logic                  o_hs,
	output logic                  o_vs,
	input  led_req_t              i_led_req,
	output logic [7:0]            o_led,
	output cfg_flags_t            o_cfg
);

	host_cmd_t             cmd;
	logic                  strobe;
	led_ovr_t              led_ovr;
	logic [4:0]            vol_att;
	logic [`HAL_AUD_W-1:0] pre_l;
	logic [`HAL_AUD_W-1:0] pre_r;
	logic                  power_on;
	logic                  disk_on;
	logic [7:0]            led_dflt;

	hps_io_port u_port (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_gp_out(i_gp_out),
		.o_cmd   (cmd),
		.o_strobe(strobe),
		.o_gp_in (o_gp_in)
	);

	cmd_decoder u_dec (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_cmd    (cmd),
		.i_strobe (strobe),
		.o_cfg    (o_cfg),
		.o_led_ovr(led_ovr),
		.o_vol_att(vol_att)
	);

	////////////////////////////////////////
	// Audio with pre-mix crossed between channels
	////////////////////////////////////////

	aud_mix u_mix_l (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sample   (i_core_audio.left),
		.i_is_signed(i_core_audio.is_signed),
		.i_mix      (i_core_audio.mix),
		.i_att      (vol_att),
		.i_pre      (pre_r),
		.o_pre      (pre_l),
		.o_audio    (o_audio_l)
	);

	aud_mix u_mix_r (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sample   (i_core_audio.right),
		.i_is_signed(i_core_audio.is_signed),
		.i_mix      (i_core_audio.mix),
		.i_att      (vol_att),
		.i_pre      (pre_l),
		.o_pre      (pre_r),
		.o_audio    (o_audio_r)
	);

	sync_fix u_sync_h (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_hs_raw),
		.o_sync (o_hs)
	);

	sync_fix u_sync_v (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_vs_raw),
		.o_sync (o_vs)
	);

	////////////////////////////////////////
	// Mainboard LEDs
	////////////////////////////////////////

	// Power is lit unless the core takes it over
	assign power_on = i_led_req.power[1] ? i_led_req.power[0] : 1'b1;
	// Without host disk activity only the core request lights it
	assign disk_on  = i_led_req.disk[0];
	assign led_dflt = {5'b00000, power_on, disk_on, i_led_req.user};

	assign o_led = (led_ovr.overtake & led_ovr.state) | (~led_ovr.overtake & led_dflt);

endmodule

// File: tb/sys_hal_asserts.sv
// Concurrent checks on the housekeeping top-level ports:
// identity and status word, acknowledge timing, reset state
`timescale 1ns/1ps
`include "hal_cfg.svh"

module sys_hal_asserts
	import hal_pkg::*;
(
	input logic                  clk_sys,
	input logic                  resetd,
	input host_cmd_t             i_gp_out,
	input logic [`HAL_GP_W-1:0]  o_gp_in,
	input logic [`HAL_AUD_W-1:0] o_audio_l,
	input logic [`HAL_AUD_W-1:0] o_audio_r,
	input cfg_flags_t            o_cfg
);

	int   fails;
	logic ack;
	logic host_on;

	assign ack     = o_gp_in[18];
	assign host_on = i_gp_out.reset_req[1];

	initial fails = 0;

	////////////////////////////////////////
	// Identity and status word
	////////////////////////////////////////

	magic_a: assert property (@(posedge clk_sys) !host_on |-> o_gp_in == `HAL_CORE_MAGIC)
	else begin
		$error("identity word differs from the core magic while bit 31 is low");
		fails++;
	end

	status_a: assert property (@(posedge clk_sys) host_on |->
		o_gp_in[31:19] == '0 && o_gp_in[17:16] == `HAL_IO_VER && o_gp_in[15:0] == '0)
	else begin
		$error("status word has a wrong version or stray bits");
		fails++;
	end

	////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////

	// Two sync stages, strobe, then ack
	ack_rise_a: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(i_gp_out.io_clk) && host_on |-> (!ack) [*4] ##1 ack)
	else begin
		$error("acknowledge did not rise 4 cycles after io_clk rose");
		fails++;
	end

	ack_fall_a: assert property (@(posedge clk_sys) disable iff (resetd)
		$fell(i_gp_out.io_clk) && host_on |-> ack [*4] ##1 !ack)
	else begin
		$error("acknowledge did not fall 4 cycles after io_clk fell");
		fails++;
	end

	reset_a: assert property (@(posedge clk_sys)
		resetd |=> o_cfg == '0 && o_audio_l == '0 && o_audio_r == '0)
	else begin
		$error("config or audio outputs not cleared by reset");
		fails++;
	end

endmodule

// File: tb/tb_sys_hal.sv
// Testbench for the housekeeping top: host handshake, command decode,
// LED merge, audio mute and mix mode 0, sync polarity fix
`timescale 1ns/1ps
`include "hal_cfg.svh"

module tb_sys_hal
	import hal_pkg::*;
();

	logic        clk_sys;
	logic        resetd;
	host_cmd_t   gp_out;
	logic [31:0] gp_in;
	core_audio_t core_audio;
	logic [15:0] audio_l;
	logic [15:0] audio_r;
	logic        hs_raw;
	logic        vs_raw;
	logic        hs;
	logic        vs;
	led_req_t    led_req;
	logic [7:0]  led;
	cfg_flags_t  cfg;
	int          errors;
	int          timeouts;

	sys_hal_top dut_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_gp_out    (gp_out),
		.o_gp_in     (gp_in),
		.i_core_audio(core_audio),
		.o_audio_l   (audio_l),
		.o_audio_r   (audio_r),
		.i_hs_raw    (hs_raw),
		.i_vs_raw    (vs_raw),
		.o_hs        (hs),
		.o_vs        (vs),
		.i_led_req   (led_req),
		.o_led       (led),
		.o_cfg       (cfg)
	);

	bind sys_hal_top sys_hal_asserts u_asserts (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_gp_out (i_gp_out),
		.o_gp_in  (o_gp_in),
		.o_audio_l(o_audio_l),
		.o_audio_r(o_audio_r),
		.o_cfg    (o_cfg)
	);

	always #10 clk_sys = ~clk_sys;

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act == exp)
		else begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Polled at the falling edge, where ack is stable
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (gp_in[18] !== level && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (gp_in[18] !== level) begin
			$display("Timeout: acknowledge never went to %0d", level);
			timeouts++;
		end
	endtask

	task automatic host_write(input logic [15:0] data);
		@(posedge clk_sys);
		gp_out.io_din <= data;
		gp_out.io_clk <= 1'b1;
		wait_ack(1'b1);
		@(posedge clk_sys);
		gp_out.io_clk <= 1'b0;
		wait_ack(1'b0);
	endtask

	// Command byte first, then one data word
	task automatic host_cmd(input logic [7:0] code, input logic [15:0] data);
		@(posedge clk_sys);
		gp_out.io_uio <= 1'b1;
		host_write({8'h00, code});
		host_write(data);
		@(posedge clk_sys);
		gp_out.io_uio <= 1'b0;
		wait_cycles(4);
	endtask

	// Power at bit 2 (dark only when the core owns it and asks for off),
	// disk at bit 1, user at bit 0
	function automatic logic [7:0] led_default(input led_req_t r);
		logic power;
		power = ~r.power[1] | r.power[0];
		return {5'd0, power, r.disk[0], r.user};
	endfunction

	// Unsigned samples are halved before the shift
	function automatic logic [15:0] mix0_expect(input logic [15:0] s, input logic sgn,
			input logic [3:0] att);
		if (sgn)
			return $signed(s) >>> att;
		return (s >> 1) >> att;
	endfunction

	// Active-low hs and active-high vs over a 36-cycle period
	task automatic run_sync(input int periods);
		for (int p = 0; p < periods; p++) begin
			for (int c = 0; c < 36; c++) begin
				@(posedge clk_sys);
				hs_raw <= (c < 30);
				vs_raw <= (c < 4);
				@(negedge clk_sys);
				if (p >= 2) begin
					check_value("sync_hs", !hs_raw, hs);
					check_value("sync_vs", vs_raw, vs);
				end
			end
		end
	endtask

	initial begin
		logic [15:0] data;
		logic [15:0] sl;
		logic [15:0] sr;
		logic [3:0]  att;
		void'($urandom(3551));
		clk_sys    = 1'b0;
		resetd     = 1'b1;
		gp_out     = '0;
		core_audio = '0;
		hs_raw     = 1'b1;
		vs_raw     = 1'b0;
		led_req    = '0;
		errors     = 0;
		timeouts   = 0;
		wait_cycles(2);
		resetd <= 1'b0;
		// Identity word on the port while the host boots
		wait_cycles(4);
		gp_out.reset_req <= 2'b10;

		////////////////////////////////////////
		// Config flags and LED override
		////////////////////////////////////////
		data = 16'($urandom);
		host_cmd(`HAL_CMD_CFG, data);
		@(negedge clk_sys);
		check_value("cfg", data, cfg);
		host_cmd(8'h7E, ~data);
		@(negedge clk_sys);
		check_value("cfg_unknown_cmd", data, cfg);

		data = 16'($urandom);
		host_cmd(`HAL_CMD_LED, data);
		repeat (8) begin
			@(posedge clk_sys);
			led_req <= 5'($urandom);
			@(negedge clk_sys);
			check_value("led", (data[15:8] & data[7:0]) |
				(~data[15:8] & led_default(led_req)), led);
		end

		////////////////////////////////////////
		// Audio mute, then mix mode 0
		////////////////////////////////////////
		host_cmd(`HAL_CMD_VOL, {11'd0, 1'b1, 4'($urandom)});
		wait_cycles(8);
		// Each sample held long enough to pass the deglitch
		repeat (5) begin
			@(posedge clk_sys);
			core_audio <= 35'({$urandom, $urandom});
			repeat (4) begin
				@(negedge clk_sys);
				check_value("mute_left", 32'd0, audio_l);
				check_value("mute_right", 32'd0, audio_r);
			end
		end

		att = 4'($urandom);
		host_cmd(`HAL_CMD_VOL, {12'd0, att});
		for (int i = 0; i < 12; i++) begin
			sl = 16'($urandom);
			sr = 16'($urandom);
			@(posedge clk_sys);
			core_audio <= '{left: sl, right: sr, is_signed: i[0], mix: 2'd0};
			wait_cycles(11);
			@(negedge clk_sys);
			check_value("mix0_left", mix0_expect(sl, i[0], att), audio_l);
			check_value("mix0_right", mix0_expect(sr, i[0], att), audio_r);
		end

		run_sync(4);

		$display("Errors: checks=%0d timeouts=%0d assertions=%0d",
			errors, timeouts, dut_i.u_asserts.fails);
		if (errors + timeouts + dut_i.u_asserts.fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+src
src/hal_pkg.sv
src/hps_io_port.sv
src/cmd_decoder.sv
src/sync_fix.sv
src/aud_mix.sv
src/sys_hal_top.sv
tb/sys_hal_asserts.sv
tb/tb_sys_hal.sv
